//--- include/controller_config.svh
`ifndef CONTROLLER_CONFIG_SVH
`define CONTROLLER_CONFIG_SVH

// raw instruction word
`define INSTR_WIDTH 32

// opcode field, top six bits
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define OPCODE_WIDTH (`OPCODE_MSB - `OPCODE_LSB + 1)

// condition field sits right below the opcode
`define COND_MSB 25
`define COND_LSB 22
`define COND_WIDTH (`COND_MSB - `COND_LSB + 1)

// N, Z, C, V
`define FLAG_COUNT 4

`endif

//--- design/isaPkg.sv
`include "controller_config.svh"

package isaPkg;

    // grouped by addressing-mode class, gaps left for the rest of the ISA
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        ADD_R   = 6'h00,
        SUB_R   = 6'h01,
        CMP_R   = 6'h02,
        SHL_R   = 6'h03,
        XOR_R   = 6'h04,

        ADD_I   = 6'h08,
        SUB_I   = 6'h09,
        AND_I   = 6'h0a,
        CMP_I   = 6'h0b,
        TST_I   = 6'h0c,
        SHL_I   = 6'h0d,
        ROR_I   = 6'h0e,

        LDW_PR  = 6'h10, // pc relative
        LDB_PR  = 6'h11,
        LDW_RO  = 6'h12, // register offset
        LDW_IA  = 6'h13, // increment after

        STW_PR  = 6'h18,
        STW_RO  = 6'h19,
        STW_IB  = 6'h1a, // increment before

        MOV_I   = 6'h20,
        MUI_I   = 6'h21, // move upper immediate
        NOT_R   = 6'h22,

        BR_PR   = 6'h28,
        BRL_PR  = 6'h29, // with link
        BR_RO   = 6'h2a,
        BRL_RO  = 6'h2b,

        ILLEGAL = 6'h3f
    } opcodes;

    // codes 8..15 are unused and never pass
    typedef enum logic [`COND_WIDTH-1:0] {
        AL = 4'h0,
        EQ = 4'h1,
        NE = 4'h2,
        CS = 4'h3,
        CC = 4'h4,
        MI = 4'h5,
        PL = 4'h6,
        NV = 4'h7
    } conditions;

    // bit positions inside the flag register
    typedef enum logic [1:0] {
        V = 2'd0,
        C = 2'd1,
        Z = 2'd2,
        N = 2'd3
    } flagIndex;

endpackage

//--- design/controlPkg.sv
package controlPkg;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2
    } states;

    // operand sources for the datapath, first part is the A side
    typedef enum logic [3:0] {
        NO_OP         = 4'd0,
        NEXTPC_IMM24  = 4'd1,  // pc relative branch
        RFA_IMM19     = 4'd2,  // register branch
        NEXTPC_IMM21B = 4'd3,
        NEXTPC_IMM21C = 4'd4,
        NULL_COMBO    = 4'd5,
        NULL_IMM21B   = 4'd6,
        NULL_RFB      = 4'd7,
        RFA_IMM16A    = 4'd8,
        RFA_IMM16B    = 4'd9,
        RFA_IMM21A    = 4'd10,
        RFA_IMM5      = 4'd11, // shift amount
        RFA_RFB       = 4'd12
    } loadControl;

endpackage

//--- design/instructionDecoder.sv
`timescale 1ns/1ns
`include "controller_config.svh"

module instructionDecoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    instrValid,
    input  controlPkg::states       state,
    input  logic [`INSTR_WIDTH-1:0] instrWord,
    output isaPkg::opcodes          opcode,
    output isaPkg::conditions       condition
);

    logic [`INSTR_WIDTH-1:0]  instrReg;
    logic [`OPCODE_WIDTH-1:0] opField;
    logic                     accept;

    assign accept = enable && instrValid && (state == controlPkg::FETCH);

    // all ones decodes as ILLEGAL / never
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrReg <= '1;
        end else if (accept) begin
            instrReg <= instrWord;
        end
    end

    assign opField   = instrReg[`OPCODE_MSB:`OPCODE_LSB];
    assign condition = isaPkg::conditions'(instrReg[`COND_MSB:`COND_LSB]);

    always_comb begin
        case (opField)
            isaPkg::ADD_R,
            isaPkg::SUB_R,
            isaPkg::CMP_R,
            isaPkg::SHL_R,
            isaPkg::XOR_R,
            isaPkg::ADD_I,
            isaPkg::SUB_I,
            isaPkg::AND_I,
            isaPkg::CMP_I,
            isaPkg::TST_I,
            isaPkg::SHL_I,
            isaPkg::ROR_I,
            isaPkg::LDW_PR,
            isaPkg::LDB_PR,
            isaPkg::LDW_RO,
            isaPkg::LDW_IA,
            isaPkg::STW_PR,
            isaPkg::STW_RO,
            isaPkg::STW_IB,
            isaPkg::MOV_I,
            isaPkg::MUI_I,
            isaPkg::NOT_R,
            isaPkg::BR_PR,
            isaPkg::BRL_PR,
            isaPkg::BR_RO,
            isaPkg::BRL_RO: opcode = isaPkg::opcodes'(opField);
            default:        opcode = isaPkg::ILLEGAL; // unassigned encoding
        endcase
    end

endmodule

//--- design/conditionEvaluator.sv
`timescale 1ns/1ns
`include "controller_config.svh"

module conditionEvaluator (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   flagsValid,
    input  logic [`FLAG_COUNT-1:0] flagsIn,
    input  isaPkg::conditions      condition,
    output logic                   conditionResult
);

    logic [`FLAG_COUNT-1:0] flags;
    logic                   flagN;
    logic                   flagZ;
    logic                   flagC;

    // status register, written by the datapath
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (enable && flagsValid) begin
            flags <= flagsIn;
        end
    end

    assign flagN = flags[isaPkg::N];
    assign flagZ = flags[isaPkg::Z];
    assign flagC = flags[isaPkg::C];

    // V is held for the datapath, no condition here tests it
    always_comb begin
        case (condition)
            isaPkg::AL: conditionResult = 1'b1;
            isaPkg::EQ: conditionResult = flagZ;
            isaPkg::NE: conditionResult = !flagZ;
            isaPkg::CS: conditionResult = flagC;
            isaPkg::CC: conditionResult = !flagC;
            isaPkg::MI: conditionResult = flagN;
            isaPkg::PL: conditionResult = !flagN;
            default:    conditionResult = 1'b0; // NV and unused codes
        endcase
    end

endmodule

//--- design/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic              instrValid,
    output controlPkg::states state
);

    controlPkg::states stateNext;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= controlPkg::FETCH;
        end else if (enable) begin // stall freezes the cycle
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;

        case (state)
            controlPkg::FETCH: begin
                // wait here until a word is offered
                if (instrValid) begin
                    stateNext = controlPkg::DECODE;
                end
            end

            controlPkg::DECODE:  stateNext = controlPkg::EXECUTE;
            controlPkg::EXECUTE: stateNext = controlPkg::FETCH;

            default: stateNext = controlPkg::FETCH; // unused encoding
        endcase
    end

endmodule

//--- design/loadOutputLogic.sv
`timescale 1ns/1ns

module loadOutputLogic (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  isaPkg::opcodes         opcode,
    input  controlPkg::states      state,
    input  logic                   conditionResult,
    output controlPkg::loadControl loadControl
);

    controlPkg::loadControl loadControlNext;

    // value shows up while the sequencer sits in EXECUTE
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loadControl <= controlPkg::NO_OP;
        end else if (enable) begin
            loadControl <= loadControlNext;
        end
    end

    always_comb begin
        loadControlNext = controlPkg::NO_OP;

        if (state == controlPkg::DECODE) begin
            case (opcode)
                // branch not taken, nothing to load
                isaPkg::BR_PR,
                isaPkg::BRL_PR: begin
                    loadControlNext = conditionResult ? controlPkg::NEXTPC_IMM24
                                                      : controlPkg::NO_OP;
                end

                isaPkg::BR_RO,
                isaPkg::BRL_RO: begin
                    loadControlNext = conditionResult ? controlPkg::RFA_IMM19
                                                      : controlPkg::NO_OP;
                end

                isaPkg::LDW_PR,
                isaPkg::LDB_PR: loadControlNext = controlPkg::NEXTPC_IMM21B;

                isaPkg::STW_PR: loadControlNext = controlPkg::NEXTPC_IMM21C;

                isaPkg::MUI_I:  loadControlNext = controlPkg::NULL_COMBO;
                isaPkg::MOV_I:  loadControlNext = controlPkg::NULL_IMM21B;
                isaPkg::NOT_R:  loadControlNext = controlPkg::NULL_RFB;

                isaPkg::ADD_I,
                isaPkg::SUB_I,
                isaPkg::AND_I,
                isaPkg::LDW_RO,
                isaPkg::LDW_IA: loadControlNext = controlPkg::RFA_IMM16A;

                isaPkg::STW_RO,
                isaPkg::STW_IB: loadControlNext = controlPkg::RFA_IMM16B;

                // compares only set flags, wider immediate
                isaPkg::CMP_I,
                isaPkg::TST_I:  loadControlNext = controlPkg::RFA_IMM21A;

                isaPkg::SHL_I,
                isaPkg::ROR_I:  loadControlNext = controlPkg::RFA_IMM5;

                isaPkg::ADD_R,
                isaPkg::SUB_R,
                isaPkg::CMP_R,
                isaPkg::SHL_R,
                isaPkg::XOR_R:  loadControlNext = controlPkg::RFA_RFB;

                default:        loadControlNext = controlPkg::NO_OP; // ILLEGAL
            endcase
        end
    end

endmodule

//--- design/controlUnit.sv
`timescale 1ns/1ns
`include "controller_config.svh"

module controlUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    instrValid,
    input  logic                    flagsValid,
    input  logic [`INSTR_WIDTH-1:0] instrWord,
    input  logic [`FLAG_COUNT-1:0]  flagsIn,
    output controlPkg::states       state,
    output controlPkg::loadControl  loadControl
);

    isaPkg::opcodes    opcode;
    isaPkg::conditions condition;
    logic              conditionResult;

    instructionDecoder decoder_i (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .instrValid (instrValid),
        .state      (state),
        .instrWord  (instrWord),
        .opcode     (opcode),
        .condition  (condition)
    );

    conditionEvaluator evaluator_i (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .flagsValid      (flagsValid),
        .flagsIn         (flagsIn),
        .condition       (condition),
        .conditionResult (conditionResult)
    );

    controlSequencer sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .instrValid (instrValid),
        .state      (state)
    );

    loadOutputLogic loadOutput_i (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .opcode          (opcode),
        .state           (state),
        .conditionResult (conditionResult),
        .loadControl     (loadControl)
    );

endmodule

//--- verif/controlUnit_properties.sv
`timescale 1ns/1ns

module controlUnitProperties (
    input logic                   clk,
    input logic                   reset,
    input logic                   enable,
    input controlPkg::states      state,
    input controlPkg::loadControl loadControl
);

    int failCount = 0; // watched from the testbench

    // the selection only lives in EXECUTE
    noLoadOutsideExecute: assert property (
        @(posedge clk) disable iff (reset)
        state != controlPkg::EXECUTE |-> loadControl == controlPkg::NO_OP
    ) else begin
        failCount++;
        $error("loadControl is not NO_OP outside EXECUTE");
    end

    stateOrder: assert property (
        @(posedge clk) disable iff (reset)
        enable |=>
            ($past(state) == controlPkg::FETCH &&
                (state == controlPkg::FETCH || state == controlPkg::DECODE)) ||
            ($past(state) == controlPkg::DECODE && state == controlPkg::EXECUTE) ||
            ($past(state) == controlPkg::EXECUTE && state == controlPkg::FETCH)
    ) else begin
        failCount++;
        $error("state left the FETCH, DECODE, EXECUTE order");
    end

    stallHold: assert property (
        @(posedge clk) disable iff (reset)
        !enable |=> $stable(state) && $stable(loadControl)
    ) else begin
        failCount++;
        $error("state or loadControl moved during a stall");
    end

endmodule

//--- verif/controlUnitTb.sv
`timescale 1ns/1ns
`include "controller_config.svh"

module controlUnitTb;

    localparam int NONBRANCH_RUNS = 22;
    localparam int BRANCH_RUNS    = 4 * 16 * 2;
    localparam int STALL_RUNS     = 20;
    localparam int ILLEGAL_RUNS   = 11;
    localparam int MAX_STALL      = 3;
    // one flag write and three cycles per instruction plus reset up front
    localparam int INSTR_CYCLES   =
        10 + 4 * (NONBRANCH_RUNS + BRANCH_RUNS + STALL_RUNS + ILLEGAL_RUNS);
    localparam int STALL_CYCLES   = STALL_RUNS * 3 * MAX_STALL;
    localparam int TIMEOUT_CYCLES = 4 * (INSTR_CYCLES + STALL_CYCLES);

    logic                    clk;
    logic                    reset;
    logic                    enable;
    logic                    instrValid;
    logic                    flagsValid;
    logic [`INSTR_WIDTH-1:0] instrWord;
    logic [`FLAG_COUNT-1:0]  flagsIn;
    controlPkg::states       state;
    controlPkg::loadControl  loadControl;

    integer                  seed;
    int unsigned             cycleCount = 0;
    logic [`FLAG_COUNT-1:0]  flagsModel;
    controlPkg::loadControl  takenLoad [64];
    bit                      knownOp   [64];
    bit                      branchOp  [64];
    logic [5:0]              opList    [$];

    controlUnit controlUnit_i (.*);

    bind controlUnit controlUnitProperties props_i (.*);

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic checkOutputs(input controlPkg::states expState,
                                input controlPkg::loadControl expLoad);
        assert (state === expState) else begin
            abortRun($sformatf("FAIL state expected %h actual %h", expState, state));
        end
        assert (loadControl === expLoad) else begin
            abortRun($sformatf("FAIL loadControl expected %h actual %h", expLoad, loadControl));
        end
    endtask

    task automatic addOp(input isaPkg::opcodes op, input controlPkg::loadControl lc,
                         input bit isBranch);
        takenLoad[op] = lc;
        knownOp[op]   = 1'b1;
        branchOp[op]  = isBranch;
        opList.push_back(op);
    endtask

    // reference table with one row per opcode
    task automatic fillTable();
        foreach (takenLoad[i]) takenLoad[i] = controlPkg::NO_OP;
        addOp(isaPkg::ADD_R,  controlPkg::RFA_RFB,       1'b0);
        addOp(isaPkg::SUB_R,  controlPkg::RFA_RFB,       1'b0);
        addOp(isaPkg::CMP_R,  controlPkg::RFA_RFB,       1'b0);
        addOp(isaPkg::SHL_R,  controlPkg::RFA_RFB,       1'b0);
        addOp(isaPkg::XOR_R,  controlPkg::RFA_RFB,       1'b0);
        addOp(isaPkg::ADD_I,  controlPkg::RFA_IMM16A,    1'b0);
        addOp(isaPkg::SUB_I,  controlPkg::RFA_IMM16A,    1'b0);
        addOp(isaPkg::AND_I,  controlPkg::RFA_IMM16A,    1'b0);
        addOp(isaPkg::CMP_I,  controlPkg::RFA_IMM21A,    1'b0);
        addOp(isaPkg::TST_I,  controlPkg::RFA_IMM21A,    1'b0);
        addOp(isaPkg::SHL_I,  controlPkg::RFA_IMM5,      1'b0);
        addOp(isaPkg::ROR_I,  controlPkg::RFA_IMM5,      1'b0);
        addOp(isaPkg::LDW_PR, controlPkg::NEXTPC_IMM21B, 1'b0);
        addOp(isaPkg::LDB_PR, controlPkg::NEXTPC_IMM21B, 1'b0);
        addOp(isaPkg::LDW_RO, controlPkg::RFA_IMM16A,    1'b0);
        addOp(isaPkg::LDW_IA, controlPkg::RFA_IMM16A,    1'b0);
        addOp(isaPkg::STW_PR, controlPkg::NEXTPC_IMM21C, 1'b0);
        addOp(isaPkg::STW_RO, controlPkg::RFA_IMM16B,    1'b0);
        addOp(isaPkg::STW_IB, controlPkg::RFA_IMM16B,    1'b0);
        addOp(isaPkg::MOV_I,  controlPkg::NULL_IMM21B,   1'b0);
        addOp(isaPkg::MUI_I,  controlPkg::NULL_COMBO,    1'b0);
        addOp(isaPkg::NOT_R,  controlPkg::NULL_RFB,      1'b0);
        addOp(isaPkg::BR_PR,  controlPkg::NEXTPC_IMM24,  1'b1); // taken value only
        addOp(isaPkg::BRL_PR, controlPkg::NEXTPC_IMM24,  1'b1);
        addOp(isaPkg::BR_RO,  controlPkg::RFA_IMM19,     1'b1);
        addOp(isaPkg::BRL_RO, controlPkg::RFA_IMM19,     1'b1);
    endtask

    function automatic bit conditionHolds(input logic [3:0] code, input logic [3:0] f);
        case (code)
            isaPkg::AL: return 1'b1;
            isaPkg::EQ: return f[isaPkg::Z];
            isaPkg::NE: return !f[isaPkg::Z];
            isaPkg::CS: return f[isaPkg::C];
            isaPkg::CC: return !f[isaPkg::C];
            isaPkg::MI: return f[isaPkg::N];
            isaPkg::PL: return !f[isaPkg::N];
            default:    return 1'b0; // NV and the unused codes
        endcase
    endfunction

    function automatic controlPkg::loadControl expectedLoad(input logic [5:0] op,
                                                            input logic [3:0] cond,
                                                            input logic [3:0] f);
        if (!knownOp[op] || (branchOp[op] && !conditionHolds(cond, f)))
            return controlPkg::NO_OP;
        return takenLoad[op];
    endfunction

    function automatic logic [`INSTR_WIDTH-1:0] makeWord(input logic [5:0] op,
                                                        input logic [3:0] cond);
        logic [`INSTR_WIDTH-1:0] word;
        word = $random(seed); // random register and immediate bits
        word[`OPCODE_MSB:`OPCODE_LSB] = op;
        word[`COND_MSB:`COND_LSB]     = cond;
        return word;
    endfunction

    task automatic stallCycle(input controlPkg::states holdState,
                              input controlPkg::loadControl holdLoad);
        enable     = 1'b0;
        instrValid = 1'b1;
        flagsValid = 1'b1;
        flagsIn    = ~flagsModel; // would flip a branch if it got through
        instrWord  = $random(seed);
        @(negedge clk);
        checkOutputs(holdState, holdLoad);
        enable     = 1'b1;
        instrValid = 1'b0;
        flagsValid = 1'b0;
    endtask

    task automatic setFlags(input logic [3:0] f);
        flagsIn    = f;
        flagsValid = 1'b1;
        @(negedge clk);
        flagsValid = 1'b0;
        flagsModel = f;
        checkOutputs(controlPkg::FETCH, controlPkg::NO_OP);
    endtask

    task automatic runInstruction(input logic [`INSTR_WIDTH-1:0] word,
                                  input controlPkg::loadControl expected,
                                  input int stallF, input int stallD, input int stallE);
        repeat (stallF) stallCycle(controlPkg::FETCH, controlPkg::NO_OP);
        instrWord  = word;
        instrValid = 1'b1;
        @(negedge clk);
        checkOutputs(controlPkg::DECODE, controlPkg::NO_OP);
        instrValid = 1'b0;
        instrWord  = $random(seed); // latched copy must be used
        repeat (stallD) stallCycle(controlPkg::DECODE, controlPkg::NO_OP);
        @(negedge clk);
        checkOutputs(controlPkg::EXECUTE, expected);
        repeat (stallE) stallCycle(controlPkg::EXECUTE, expected);
        @(negedge clk);
        checkOutputs(controlPkg::FETCH, controlPkg::NO_OP);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            abortRun("timeout: the test sequence did not finish in time");
        end
    end

    always @(negedge clk) begin
        if (controlUnit_i.props_i.failCount != 0) begin
            abortRun("a concurrent assertion on the control unit failed");
        end
    end

    initial begin
        logic [31:0] r;
        logic [5:0]  op;
        logic [3:0]  cond;
        int          idx;

        seed       = 32'h62715d9a;
        reset      = 1'b1;
        enable     = 1'b0;
        instrValid = 1'b0;
        flagsValid = 1'b0;
        instrWord  = '0;
        flagsIn    = '0;
        flagsModel = '0;
        fillTable();
        repeat (8) @(negedge clk);
        reset  = 1'b0;
        enable = 1'b1;
        checkOutputs(controlPkg::FETCH, controlPkg::NO_OP);
        @(negedge clk);
        checkOutputs(controlPkg::FETCH, controlPkg::NO_OP); // idle with nothing offered

        foreach (opList[i]) begin
            if (!branchOp[opList[i]]) begin
                r = $random(seed);
                runInstruction(makeWord(opList[i], r[3:0]), takenLoad[opList[i]], 0, 0, 0);
            end
        end

        // each code against a flag set and its inverse
        foreach (opList[i]) begin
            if (branchOp[opList[i]]) begin
                for (int code = 0; code < 16; code++) begin
                    r = $random(seed);
                    for (int pass = 0; pass < 2; pass++) begin
                        setFlags(pass ? ~r[3:0] : r[3:0]);
                        runInstruction(makeWord(opList[i], code[3:0]),
                                       expectedLoad(opList[i], code[3:0], flagsModel), 0, 0, 0);
                    end
                end
            end
        end

        for (int k = 0; k < STALL_RUNS; k++) begin
            r   = $random(seed);
            idx = r[15:8] % opList.size();
            op  = opList[idx];
            // even runs take a branch whose condition reads the flags
            while (k % 2 == 0 && !branchOp[op]) begin
                r   = $random(seed);
                idx = r[15:8] % opList.size();
                op  = opList[idx];
            end
            cond = 4'(1 + (r[7:4] % 6));
            setFlags(r[3:0]);
            runInstruction(makeWord(op, cond), expectedLoad(op, cond, flagsModel),
                           r[19:18], 1 + (r[17:16] % MAX_STALL), 1 + (r[21:20] % MAX_STALL));
        end

        runInstruction(makeWord(6'h3f, 4'h0), controlPkg::NO_OP, 0, 0, 0);
        repeat (ILLEGAL_RUNS - 1) begin
            r  = $random(seed);
            op = r[5:0];
            while (knownOp[op]) begin
                r  = $random(seed);
                op = r[5:0];
            end
            runInstruction(makeWord(op, r[9:6]), controlPkg::NO_OP, 0, 0, 0);
        end

        if (controlUnit_i.props_i.failCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abortRun("a concurrent assertion on the control unit failed");
        end
    end

endmodule

//--- build.f
+incdir+include
design/isaPkg.sv
design/controlPkg.sv
design/instructionDecoder.sv
design/conditionEvaluator.sv
design/controlSequencer.sv
design/loadOutputLogic.sv
design/controlUnit.sv
verif/controlUnit_properties.sv
verif/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/isaPkg.sv
      - design/controlPkg.sv
      - design/instructionDecoder.sv
      - design/conditionEvaluator.sv
      - design/controlSequencer.sv
      - design/loadOutputLogic.sv
      - design/controlUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/controlUnit_properties.sv
      - verif/controlUnitTb.sv
